/* design/dbg_wb_settings.svh */
`ifndef DBG_WB_SETTINGS_SVH
`define DBG_WB_SETTINGS_SVH

//////////////////////////////////////////////////
// Bus byte order
//////////////////////////////////////////////////

// 1'b0 puts byte address 0 on lane 3 (big endian)
// Set to 1'b1 for little endian lane order
`define DBG_WB_LITTLE_ENDIAN 1'b0

//////////////////////////////////////////////////
// Burst and address map
//////////////////////////////////////////////////

// Width of the burst word count
`define DBG_WB_CNT_W 8
// Top address nibble of the region the slave rejects
`define DBG_WB_ERR_NIB 4'hF

`endif

/* design/dbg_wb_pkg.sv */
`include "dbg_wb_settings.svh"

package dbg_wb_pkg;

  //////////////////////////////////////////////////
  // Access size
  //////////////////////////////////////////////////

  // Encoded as the number of bytes per access
  typedef enum logic [2:0] {
    size_byte = 3'd1,
    size_half = 3'd2,
    size_word = 3'd4
  } access_size_e;

  //////////////////////////////////////////////////
  // Request and command words
  //////////////////////////////////////////////////

  // One bus access handed from the sequencer to the BIU
  // Short write data sits in the upper bits
  typedef struct packed {
    logic [31:0]  addr;
    logic [31:0]  wdata;
    access_size_e size;
    logic         write;
  } bus_req_t;

  // Host command, count is number of accesses minus one
  typedef struct packed {
    logic [31:0]               addr;
    access_size_e              size;
    logic                      write;
    logic [`DBG_WB_CNT_W-1:0]  count;
  } dbg_cmd_t;

endpackage

/* design/dbg_wb_toggle_sync.sv */
`timescale 1ns/1ps

module dbg_wb_toggle_sync (
  input  logic dst_clk_i,
  input  logic rst_i,
  input  logic tog_i,
  output logic pulse_o
);

  // Two-stage synchronizer
  logic meta_q;
  logic sync_q;
  // Previous synchronized level, for edge detection
  logic edge_q;

  always_ff @(posedge dst_clk_i or posedge rst_i) begin
    if (rst_i) begin
      meta_q <= 1'b0;
      sync_q <= 1'b0;
      edge_q <= 1'b0;
    end else begin
      meta_q <= tog_i;
      sync_q <= meta_q;
      edge_q <= sync_q;
    end
  end

  // Any change of level is one event
  assign pulse_o = sync_q ^ edge_q;

endmodule

/* design/dbg_wb_lane_steer.sv */
`timescale 1ns/1ps
`include "dbg_wb_settings.svh"

module dbg_wb_lane_steer (
  input  dbg_wb_pkg::access_size_e size_i,
  input  logic [1:0]               addr_lo_i,
  input  logic [3:0]               sel_i,
  input  logic [31:0]              host_wdata_i,
  input  logic [31:0]              bus_rdata_i,
  output logic [3:0]               sel_o,
  output logic [31:0]              bus_wdata_o,
  output logic [31:0]              host_rdata_o
);

  import dbg_wb_pkg::*;

  localparam bit little_endian = `DBG_WB_LITTLE_ENDIAN;

  // Lane holding the addressed byte
  logic [1:0] byte_lane;
  // Lowest lane of the addressed halfword
  logic [1:0] half_lane;

  //////////////////////////////////////////////////
  // Byte select decode
  //////////////////////////////////////////////////

  // Big endian mirrors the lane index, 3 - a
  assign byte_lane = little_endian ? addr_lo_i : ~addr_lo_i;
  assign half_lane = little_endian ? {addr_lo_i[1], 1'b0} : {~addr_lo_i[1], 1'b0};

  always_comb begin
    case (size_i)
      size_byte: sel_o = 4'b0001 << byte_lane;
      size_half: sel_o = 4'b0011 << half_lane;
      // Word, and any unknown size
      default:   sel_o = 4'b1111;
    endcase
  end

  //////////////////////////////////////////////////
  // Host to bus, upper host bits onto the lanes
  //////////////////////////////////////////////////

  always_comb begin
    case (sel_o)
      4'b1100: bus_wdata_o = {host_wdata_i[31:16], 16'h0};
      4'b0011: bus_wdata_o = {16'h0, host_wdata_i[31:16]};
      4'b1000: bus_wdata_o = {host_wdata_i[31:24], 24'h0};
      4'b0100: bus_wdata_o = {8'h0, host_wdata_i[31:24], 16'h0};
      4'b0010: bus_wdata_o = {16'h0, host_wdata_i[31:24], 8'h0};
      4'b0001: bus_wdata_o = {24'h0, host_wdata_i[31:24]};
      default: bus_wdata_o = host_wdata_i;
    endcase
  end

  //////////////////////////////////////////////////
  // Bus to host, selected lanes into low bits
  //////////////////////////////////////////////////

  // Unselected lanes are dropped, result zero-extended
  always_comb begin
    case (sel_i)
      4'b1100: host_rdata_o = {16'h0, bus_rdata_i[31:16]};
      4'b0011: host_rdata_o = {16'h0, bus_rdata_i[15:0]};
      4'b1000: host_rdata_o = {24'h0, bus_rdata_i[31:24]};
      4'b0100: host_rdata_o = {24'h0, bus_rdata_i[23:16]};
      4'b0010: host_rdata_o = {24'h0, bus_rdata_i[15:8]};
      4'b0001: host_rdata_o = {24'h0, bus_rdata_i[7:0]};
      default: host_rdata_o = bus_rdata_i;
    endcase
  end

endmodule

/* design/dbg_wb_biu.sv */
`timescale 1ns/1ps

module dbg_wb_biu (
  // Debug side, tck_i domain
  input  logic                tck_i,
  input  logic                rst_i,
  input  dbg_wb_pkg::bus_req_t req_i,
  input  logic                strobe_i,
  output logic                rdy_o,
  output logic [31:0]         rdata_o,
  output logic                err_o,
  // Wishbone side, wb_clk_i domain
  input  logic                wb_clk_i,
  output logic [31:0]         wb_adr_o,
  output logic [31:0]         wb_dat_o,
  input  logic [31:0]         wb_dat_i,
  output logic [3:0]          wb_sel_o,
  output logic                wb_we_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  input  logic                wb_ack_i,
  input  logic                wb_err_i
);

  typedef enum logic {wb_idle, wb_xfer} wb_state_e;

  // Latched request, read by the bus side
  logic [31:0] adr_q;
  logic [31:0] dat_q;
  logic [3:0]  sel_q;
  logic        we_q;
  // Steered values
  logic [3:0]  sel_dec;
  logic [31:0] wdata_steer;
  logic [31:0] rdata_steer;
  // Toggle-active crossing signals and their pulses
  logic        str_tog;
  logic        rdy_tog;
  logic        start_pulse;
  logic        rdy_pulse;
  logic        accept;
  // Bus FSM
  wb_state_e   wb_state_q;
  logic        bus_active;
  logic        bus_done;
  logic        rdata_q;
  logic [31:0] rdata_reg;
  logic        err_q;

  dbg_wb_lane_steer u_steer (
    .size_i       (req_i.size),
    .addr_lo_i    (req_i.addr[1:0]),
    .sel_i        (sel_q),
    .host_wdata_i (req_i.wdata),
    .bus_rdata_i  (wb_dat_i),
    .sel_o        (sel_dec),
    .bus_wdata_o  (wdata_steer),
    .host_rdata_o (rdata_steer)
  );

  //////////////////////////////////////////////////
  // TCK domain
  //////////////////////////////////////////////////

  assign accept = strobe_i && rdy_o;

  // Request fields, held for the whole bus cycle
  always_ff @(posedge tck_i) begin
    if (accept) begin
      adr_q <= req_i.addr;
      sel_q <= sel_dec;
      dat_q <= wdata_steer;
      we_q  <= req_i.write;
    end
  end

  // Start toggle out, ready level back in
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      str_tog <= 1'b0;
      rdy_o   <= 1'b1;
    end else if (accept) begin
      str_tog <= ~str_tog;
      rdy_o   <= 1'b0;
    end else if (rdy_pulse) begin
      rdy_o   <= 1'b1;
    end
  end

  dbg_wb_toggle_sync u_rdy_sync (
    .dst_clk_i (tck_i),
    .rst_i     (rst_i),
    .tog_i     (rdy_tog),
    .pulse_o   (rdy_pulse)
  );

  dbg_wb_toggle_sync u_str_sync (
    .dst_clk_i (wb_clk_i),
    .rst_i     (rst_i),
    .tog_i     (str_tog),
    .pulse_o   (start_pulse)
  );

  //////////////////////////////////////////////////
  // Wishbone domain
  //////////////////////////////////////////////////

  // Cycle opens on the start pulse itself
  // Ack in that same cycle ends the access there
  assign bus_active = (wb_state_q == wb_xfer) || start_pulse;
  assign bus_done   = bus_active && (wb_ack_i || wb_err_i);
  // Read data wanted only on a good read
  assign rdata_q    = bus_done && wb_ack_i && !we_q;

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wb_state_q <= wb_idle;
      rdy_tog    <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      if (bus_done) begin
        wb_state_q <= wb_idle;
        err_q      <= wb_err_i;
        rdy_tog    <= ~rdy_tog;
      end else if (bus_active) begin
        wb_state_q <= wb_xfer;
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rdata_q) begin
      rdata_reg <= rdata_steer;
    end
  end

  assign wb_cyc_o = bus_active;
  assign wb_stb_o = bus_active;
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;
  assign wb_sel_o = sel_q;
  assign wb_we_o  = we_q;
  // Both settle before the ready toggle crosses back
  assign rdata_o  = rdata_reg;
  assign err_o    = err_q;

endmodule

/* design/dbg_wb_cmd_seq.sv */
`timescale 1ns/1ps
`include "dbg_wb_settings.svh"

module dbg_wb_cmd_seq (
  input  logic                 tck_i,
  input  logic                 rst_i,
  // Host side
  input  logic                 cmd_go_i,
  input  dbg_wb_pkg::dbg_cmd_t cmd_i,
  input  logic                 wr_strobe_i,
  input  logic [31:0]          wr_data_i,
  output logic                 need_data_o,
  output logic                 rd_valid_o,
  output logic [31:0]          rd_data_o,
  output logic                 busy_o,
  output logic                 done_o,
  output logic                 err_o,
  // BIU side
  output dbg_wb_pkg::bus_req_t req_o,
  output logic                 strobe_o,
  input  logic                 biu_rdy_i,
  input  logic [31:0]          biu_rdata_i,
  input  logic                 biu_err_i
);

  import dbg_wb_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_get_data,
    st_issue,
    st_wait,
    st_finish
  } seq_state_e;

  seq_state_e               state_q;
  // Current access
  logic [31:0]              addr_q;
  access_size_e             size_q;
  logic                     write_q;
  // Accesses left after the current one
  logic [`DBG_WB_CNT_W-1:0] count_q;
  logic [31:0]              wdata_q;
  // BIU ready, one cycle back
  logic                     rdy_q;
  logic                     rdy_rise;

  //////////////////////////////////////////////////
  // Status and request outputs
  //////////////////////////////////////////////////

  assign rdy_rise    = biu_rdy_i && !rdy_q;
  assign busy_o      = (state_q != st_idle);
  assign need_data_o = (state_q == st_get_data);
  assign strobe_o    = (state_q == st_issue) && biu_rdy_i;
  assign done_o      = (state_q == st_finish);
  assign req_o       = '{addr: addr_q, wdata: wdata_q, size: size_q, write: write_q};

  //////////////////////////////////////////////////
  // Burst FSM
  //////////////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= st_idle;
      addr_q     <= 32'h0;
      size_q     <= size_word;
      write_q    <= 1'b0;
      count_q    <= '0;
      rdy_q      <= 1'b1;
      err_o      <= 1'b0;
      rd_valid_o <= 1'b0;
    end else begin
      rdy_q      <= biu_rdy_i;
      rd_valid_o <= 1'b0;
      case (state_q)
        st_idle: begin
          if (cmd_go_i) begin
            addr_q  <= cmd_i.addr;
            size_q  <= cmd_i.size;
            write_q <= cmd_i.write;
            count_q <= cmd_i.count;
            err_o   <= 1'b0;
            state_q <= cmd_i.write ? st_get_data : st_issue;
          end
        end
        st_get_data: begin
          // Host may take any number of cycles
          if (wr_strobe_i) begin
            state_q <= st_issue;
          end
        end
        st_issue: begin
          if (biu_rdy_i) begin
            state_q <= st_wait;
          end
        end
        st_wait: begin
          if (rdy_rise) begin
            if (biu_err_i) begin
              // Abort the rest of the burst
              err_o   <= 1'b1;
              state_q <= st_finish;
            end else begin
              rd_valid_o <= !write_q;
              // Size value equals its byte count
              addr_q     <= addr_q + {29'd0, size_q};
              if (count_q == '0) begin
                state_q <= st_finish;
              end else begin
                count_q <= count_q - 1'b1;
                state_q <= write_q ? st_get_data : st_issue;
              end
            end
          end
        end
        st_finish: state_q <= st_idle;
        default:   state_q <= st_idle;
      endcase
    end
  end

  // Data words in and out
  always_ff @(posedge tck_i) begin
    if ((state_q == st_get_data) && wr_strobe_i) begin
      wdata_q <= wr_data_i;
    end
    if ((state_q == st_wait) && rdy_rise && !write_q) begin
      rd_data_o <= biu_rdata_i;
    end
  end

endmodule

/* design/dbg_wb_top.sv */
`timescale 1ns/1ps

module dbg_wb_top (
  input  logic                 tck_i,
  input  logic                 rst_i,
  // Host
  input  logic                 cmd_go_i,
  input  dbg_wb_pkg::dbg_cmd_t cmd_i,
  input  logic                 wr_strobe_i,
  input  logic [31:0]          wr_data_i,
  output logic                 need_data_o,
  output logic                 rd_valid_o,
  output logic [31:0]          rd_data_o,
  output logic                 busy_o,
  output logic                 done_o,
  output logic                 err_o,
  // Wishbone
  input  logic                 wb_clk_i,
  output logic [31:0]          wb_adr_o,
  output logic [31:0]          wb_dat_o,
  input  logic [31:0]          wb_dat_i,
  output logic [3:0]           wb_sel_o,
  output logic                 wb_we_o,
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  input  logic                 wb_ack_i,
  input  logic                 wb_err_i
);

  import dbg_wb_pkg::*;

  // Sequencer to BIU
  bus_req_t    biu_req;
  logic        biu_strobe;
  logic        biu_rdy;
  logic [31:0] biu_rdata;
  logic        biu_err;

  dbg_wb_cmd_seq u_seq (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .cmd_go_i    (cmd_go_i),
    .cmd_i       (cmd_i),
    .wr_strobe_i (wr_strobe_i),
    .wr_data_i   (wr_data_i),
    .need_data_o (need_data_o),
    .rd_valid_o  (rd_valid_o),
    .rd_data_o   (rd_data_o),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .err_o       (err_o),
    .req_o       (biu_req),
    .strobe_o    (biu_strobe),
    .biu_rdy_i   (biu_rdy),
    .biu_rdata_i (biu_rdata),
    .biu_err_i   (biu_err)
  );

  dbg_wb_biu u_biu (
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .req_i    (biu_req),
    .strobe_i (biu_strobe),
    .rdy_o    (biu_rdy),
    .rdata_o  (biu_rdata),
    .err_o    (biu_err),
    .wb_clk_i (wb_clk_i),
    .wb_adr_o (wb_adr_o),
    .wb_dat_o (wb_dat_o),
    .wb_dat_i (wb_dat_i),
    .wb_sel_o (wb_sel_o),
    .wb_we_o  (wb_we_o),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_ack_i (wb_ack_i),
    .wb_err_i (wb_err_i)
  );

endmodule

/* verif/dbg_wb_mem_model.sv */
`timescale 1ns/1ps
`include "dbg_wb_settings.svh"

module dbg_wb_mem_model (
  input  logic        wb_clk_i,
  input  logic        rst_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  input  logic [3:0]  wb_sel_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  output logic        wb_ack_o,
  output logic        wb_err_o
);

  // 256 words, lane k is bits 8k+7:8k
  logic [31:0] mem [0:255];
  // Wait cycles chosen for the next access, and cycles waited so far
  logic [1:0]  dly_q;
  logic [1:0]  wait_q;
  logic        req;
  logic        respond;
  logic        in_err;

  // Fill pattern built from the word address
  initial begin
    logic [7:0] idx;
    for (int w = 0; w < 256; w++) begin
      idx    = 8'(w);
      mem[w] = {idx, ~idx, idx ^ 8'h3C, idx + 8'h81};
    end
  end

  assign req      = wb_cyc_i && wb_stb_i;
  assign in_err   = (wb_adr_i[31:28] == `DBG_WB_ERR_NIB);
  // Zero delay answers in the first cycle of stb
  assign respond  = req && (wait_q == dly_q);
  assign wb_ack_o = respond && !in_err;
  assign wb_err_o = respond && in_err;
  assign wb_dat_o = mem[wb_adr_i[9:2]];

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wait_q <= 2'd0;
      dly_q  <= 2'd0;
    end else if (respond) begin
      wait_q <= 2'd0;
      dly_q  <= 2'($urandom_range(0, 3));
    end else if (req) begin
      wait_q <= wait_q + 2'd1;
    end
  end

  // Byte lane writes, only on a good ack
  always @(posedge wb_clk_i) begin
    if (wb_ack_o && wb_we_i) begin
      for (int k = 0; k < 4; k++) begin
        if (wb_sel_i[k]) begin
          mem[wb_adr_i[9:2]][8*k +: 8] <= wb_dat_i[8*k +: 8];
        end
      end
    end
  end

endmodule

/* verif/dbg_wb_checker.sv */
`timescale 1ns/1ps

module dbg_wb_checker (
  input logic        tck_i,
  input logic        wb_clk_i,
  input logic        rst_i,
  input logic        cyc_i,
  input logic        stb_i,
  input logic [31:0] adr_i,
  input logic [3:0]  sel_i,
  input logic        ack_i,
  input logic        err_i,
  input logic        rdy_i
);

  // Count of failed properties
  int fail_cnt = 0;

  //////////////////////////////////////////////////
  // Wishbone side
  //////////////////////////////////////////////////

  stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    stb_i |-> cyc_i)
    else begin
      fail_cnt++;
      $error("wb_stb_o high without wb_cyc_o");
    end

  // Strobe and address hold until the slave answers
  stb_hold: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    stb_i && !ack_i && !err_i |=> stb_i && $stable(adr_i))
    else begin
      fail_cnt++;
      $error("wb_stb_o or wb_adr_o changed before ack or err");
    end

  sel_nonzero: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    stb_i |-> (sel_i != 4'b0000))
    else begin
      fail_cnt++;
      $error("wb_sel_o is zero during a strobe");
    end

  //////////////////////////////////////////////////
  // Debug side
  //////////////////////////////////////////////////

  // Ready only returns once the bus cycle is closed
  rdy_after_cyc: assert property (@(posedge tck_i) disable iff (rst_i)
    $rose(rdy_i) |-> !cyc_i)
    else begin
      fail_cnt++;
      $error("rdy rose while wb_cyc_o was high");
    end

endmodule

/* verif/dbg_wb_tb.sv */
`timescale 1ns/1ps
`include "dbg_wb_settings.svh"

module dbg_wb_tb;

  import dbg_wb_pkg::*;

  //////////////////////////////////////////////////
  // Run length and limits
  //////////////////////////////////////////////////

  localparam int cnt_w  = `DBG_WB_CNT_W;
  localparam int n_rand = 12;
  localparam int n_busy = 6;
  // Worst case access count, bursts are at most 8 long
  localparam int max_accesses   = 2 + 32 + (n_rand + n_busy) * 2 * 8 + 16;
  localparam int timeout_cycles = max_accesses * 30;

  logic        tck = 1'b0;
  logic        wb_clk = 1'b0;
  logic        rst;
  // Host side
  logic        cmd_go;
  dbg_cmd_t    cmd;
  logic        wr_strobe;
  logic [31:0] wr_data;
  logic        need_data;
  logic        rd_valid;
  logic [31:0] rd_data;
  logic        busy;
  logic        done;
  logic        err;
  // Wishbone side
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic [3:0]  wb_sel;
  logic        wb_we;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_ack;
  logic        wb_err;

  // Byte image of the slave, aliased on the low 10 address bits
  logic [7:0]  shadow [0:1023];
  logic [31:0] exp_q[$];
  int          done_cnt;
  int          tck_cycles = 0;

  always #2 wb_clk = ~wb_clk;
  always #5 tck = ~tck;

  dbg_wb_top dut0 (
    .tck_i       (tck),
    .rst_i       (rst),
    .cmd_go_i    (cmd_go),
    .cmd_i       (cmd),
    .wr_strobe_i (wr_strobe),
    .wr_data_i   (wr_data),
    .need_data_o (need_data),
    .rd_valid_o  (rd_valid),
    .rd_data_o   (rd_data),
    .busy_o      (busy),
    .done_o      (done),
    .err_o       (err),
    .wb_clk_i    (wb_clk),
    .wb_adr_o    (wb_adr),
    .wb_dat_o    (wb_dat_w),
    .wb_dat_i    (wb_dat_r),
    .wb_sel_o    (wb_sel),
    .wb_we_o     (wb_we),
    .wb_cyc_o    (wb_cyc),
    .wb_stb_o    (wb_stb),
    .wb_ack_i    (wb_ack),
    .wb_err_i    (wb_err)
  );

  dbg_wb_mem_model mem0 (
    .wb_clk_i (wb_clk),
    .rst_i    (rst),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_sel_i (wb_sel),
    .wb_we_i  (wb_we),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err)
  );

  bind dbg_wb_biu dbg_wb_checker chk0 (
    .tck_i    (tck_i),
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .cyc_i    (wb_cyc_o),
    .stb_i    (wb_stb_o),
    .adr_i    (wb_adr_o),
    .sel_i    (wb_sel_o),
    .ack_i    (wb_ack_i),
    .err_i    (wb_err_i),
    .rdy_i    (rdy_o)
  );

  //////////////////////////////////////////////////
  // Reporting and reference model
  //////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] got);
    assert (got === exp_val)
      else report_failure($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp_val, got));
  endtask

  function automatic int size_bytes(input access_size_e size);
    case (size)
      size_byte: return 1;
      size_half: return 2;
      default:   return 4;
    endcase
  endfunction

  function automatic access_size_e pick_size();
    case ($urandom_range(0, 2))
      0:       return size_byte;
      1:       return size_half;
      default: return size_word;
    endcase
  endfunction

  // Bus lane of a byte address, big endian puts byte 0 on lane 3
  function automatic int lane_of(input logic [31:0] a);
    return `DBG_WB_LITTLE_ENDIAN ? int'(a[1:0]) : 3 - int'(a[1:0]);
  endfunction

  // Expected host value, short reads zero-extended in the low bits
  function automatic logic [31:0] dbg_ref_read(input logic [31:0] addr,
                                               input access_size_e size);
    int          nb;
    logic [31:0] base;
    logic [31:0] a;
    logic [31:0] val;
    nb   = size_bytes(size);
    // Halfwords and words ignore the low address bits below their size
    base = addr & ~(32'(nb) - 32'd1);
    val  = 32'h0;
    for (int i = 0; i < nb; i++) begin
      a = base + 32'(i);
      if (`DBG_WB_LITTLE_ENDIAN) begin
        val[8*i +: 8] = shadow[a[9:0]];
      end else begin
        val[8*(nb-1-i) +: 8] = shadow[a[9:0]];
      end
    end
    return val;
  endfunction

  // Host write data carries short values in its upper bits
  task automatic shadow_store(input logic [31:0] addr, input access_size_e size,
                              input logic [31:0] data);
    int          nb;
    logic [31:0] base;
    logic [31:0] a;
    logic [31:0] val;
    nb   = size_bytes(size);
    base = addr & ~(32'(nb) - 32'd1);
    val  = data >> (32 - 8 * nb);
    for (int i = 0; i < nb; i++) begin
      a = base + 32'(i);
      if (`DBG_WB_LITTLE_ENDIAN) begin
        shadow[a[9:0]] = val[8*i +: 8];
      end else begin
        shadow[a[9:0]] = val[8*(nb-1-i) +: 8];
      end
    end
  endtask

  // Start from the slave's fill pattern
  task automatic load_shadow();
    logic [31:0] a;
    for (int i = 0; i < 1024; i++) begin
      a         = 32'(i);
      shadow[i] = mem0.mem[a[9:2]][8 * lane_of(a) +: 8];
    end
  endtask

  //////////////////////////////////////////////////
  // Host driver
  //////////////////////////////////////////////////

  // Called and returns 1 ns after a rising tck
  task automatic run_cmd(input logic [31:0] addr, input access_size_e size,
                         input logic write, input int count, input bit poke_busy);
    dbg_cmd_t    c;
    logic [31:0] a;
    logic [31:0] data;
    int          nb;
    int          n_ok;
    bit          exp_err;
    int          words;
    bit          poked;
    nb      = size_bytes(size);
    n_ok    = 0;
    exp_err = 1'b0;
    words   = 0;
    poked   = 1'b0;
    // Accesses up to the first one in the error region
    for (int i = 0; i <= count; i++) begin
      a = addr + 32'(i * nb);
      if (!exp_err && a[31:28] == `DBG_WB_ERR_NIB) begin
        exp_err = 1'b1;
      end else if (!exp_err) begin
        n_ok++;
        if (!write) begin
          exp_q.push_back(dbg_ref_read(a, size));
        end
      end
    end
    c = '{addr: addr, size: size, write: write, count: cnt_w'(count)};
    while (busy) begin
      @(posedge tck);
      #1;
    end
    done_cnt = 0;
    cmd      = c;
    cmd_go   = 1'b1;
    @(posedge tck);
    #1;
    cmd_go   = 1'b0;
    assert (busy === 1'b1) else report_failure("command was not accepted while idle");
    // A new command clears the error flag
    check_value("err_o", 32'h0, {31'h0, err});
    while (done !== 1'b1) begin
      if (need_data === 1'b1) begin
        // Random host gap before each write word
        repeat ($urandom_range(0, 3)) begin
          @(posedge tck);
          #1;
        end
        data      = $urandom;
        wr_data   = data;
        wr_strobe = 1'b1;
        // The failing access never reaches memory
        if (words < n_ok) begin
          shadow_store(addr + 32'(words * nb), size, data);
        end
        words++;
        @(posedge tck);
        #1;
        wr_strobe = 1'b0;
      end else if (poke_busy && !poked) begin
        // Second command while busy, must be dropped
        cmd    = '{addr: 32'h40, size: size_word, write: 1'b1, count: '0};
        cmd_go = 1'b1;
        poked  = 1'b1;
        @(posedge tck);
        #1;
        cmd_go = 1'b0;
      end else begin
        @(posedge tck);
        #1;
      end
    end
    // Compare process samples the last cycle at its falling edge
    @(negedge tck);
    #1;
    assert (exp_q.size() == 0) else report_failure("burst ended with reads not delivered");
    assert (done_cnt == 1) else report_failure("done_o did not pulse exactly once");
    check_value("err_o", 32'(exp_err), {31'h0, err});
    assert (words == (write ? n_ok + int'(exp_err) : 0))
      else report_failure("sequencer asked for the wrong number of write words");
    @(posedge tck);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Compare process and run limit
  //////////////////////////////////////////////////

  always @(negedge tck) begin
    logic [31:0] exp_val;
    if (!rst) begin
      if (rd_valid === 1'b1) begin
        assert (exp_q.size() > 0)
          else report_failure("rd_valid_o pulsed with no read outstanding");
        exp_val = exp_q.pop_front();
        check_value("rd_data_o", exp_val, rd_data);
      end
      if (done === 1'b1) begin
        done_cnt++;
      end
      assert (dut0.u_biu.chk0.fail_cnt == 0)
        else report_failure("a bus protocol assertion failed");
    end
  end

  always @(posedge tck) begin
    tck_cycles <= tck_cycles + 1;
    assert (tck_cycles < timeout_cycles)
      else report_failure("run hung, no end of test within the cycle limit");
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0]  a;
    access_size_e sz;
    int           cnt;
    void'($urandom(34513));
    rst       = 1'b1;
    cmd_go    = 1'b0;
    cmd       = '0;
    wr_strobe = 1'b0;
    wr_data   = 32'h0;
    repeat (4) @(posedge wb_clk);
    @(posedge tck);
    #1;
    rst = 1'b0;
    load_shadow();

    // Idle state after reset, then one word write and read
    check_value("busy_o", 32'h0, {31'h0, busy});
    check_value("done_o", 32'h0, {31'h0, done});
    check_value("err_o", 32'h0, {31'h0, err});
    check_value("wb_cyc_o", 32'h0, {31'h0, wb_cyc});
    check_value("wb_stb_o", 32'h0, {31'h0, wb_stb});
    run_cmd(32'h20, size_word, 1'b1, 0, 1'b0);
    run_cmd(32'h20, size_word, 1'b0, 0, 1'b0);

    // Short writes at every low address, read back at all sizes
    for (int lo = 0; lo < 4; lo++) begin
      for (int s = 0; s < 2; s++) begin
        a  = (32'($urandom_range(0, 255)) << 2) + 32'(lo);
        sz = (s == 0) ? size_byte : size_half;
        run_cmd(a, sz, 1'b1, 0, 1'b0);
        run_cmd(a, size_word, 1'b0, 0, 1'b0);
        run_cmd(a, size_half, 1'b0, 0, 1'b0);
        run_cmd(a, size_byte, 1'b0, 0, 1'b0);
      end
    end

    // Random bursts, the last group also pokes cmd_go while busy
    for (int n = 0; n < n_rand + n_busy; n++) begin
      a   = 32'($urandom_range(0, 991));
      sz  = pick_size();
      cnt = $urandom_range(0, 7);
      run_cmd(a, sz, 1'b1, cnt, n >= n_rand);
      run_cmd(a, sz, 1'b0, cnt, n >= n_rand);
    end

    // Bursts running into the error region
    run_cmd(32'hEFFF_FFF8, size_word, 1'b1, 3, 1'b0);
    run_cmd(32'hEFFF_FFF8, size_half, 1'b0, 7, 1'b0);
    run_cmd(32'hF000_0010, size_byte, 1'b1, 0, 1'b0);
    run_cmd(32'hEFFF_FFF8, size_word, 1'b0, 1, 1'b0);

    if (dut0.u_biu.chk0.fail_cnt == 0 && exp_q.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      report_failure("bus protocol check or read queue failing at end of run");
    end
  end

endmodule

/* dbg_wb.f */
+incdir+design
design/dbg_wb_pkg.sv
design/dbg_wb_toggle_sync.sv
design/dbg_wb_lane_steer.sv
design/dbg_wb_biu.sv
design/dbg_wb_cmd_seq.sv
design/dbg_wb_top.sv
verif/dbg_wb_mem_model.sv
verif/dbg_wb_checker.sv
verif/dbg_wb_tb.sv
